// ==== dv/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

  // Instruction encoders for the base RV formats
  function automatic logic [31:0] imm_op(int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] reg_op(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] lui_op(int rd, int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] jal_op(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] branch_op(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  // One retirement per call, its word also goes into the program image
  task automatic add_step(input logic [`CORE_XLEN-1:0] pc, input logic [31:0] word,
                          input int rd, input logic [`CORE_XLEN-1:0] data);
    int idx;
    idx = int'((pc - ENTRY) >> 2);
    if (idx < MEM_WORDS) begin
      mem[idx] = word;
    end
    exp_pc[n_steps]   = pc;
    exp_rd[n_steps]   = rd[4:0];
    exp_data[n_steps] = data;
    n_steps++;
  endtask

  // Steps in retirement order, skipped slots stay NOP
  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = NOP_WORD;
    end
    n_steps = 0;
    add_step(64'h1000, imm_op(0, 1, 0, 'h123), 1, 64'h123);
    add_step(64'h1004, imm_op(0, 2, 0, -5), 2, 64'hffff_ffff_ffff_fffb);
    add_step(64'h1008, imm_op(7, 3, 1, 'h0f0), 3, 64'h20);
    add_step(64'h100c, imm_op(6, 4, 1, 'h400), 4, 64'h523);
    add_step(64'h1010, imm_op(4, 5, 2, -1), 5, 64'h4);
    add_step(64'h1014, reg_op(0, 0, 6, 5, 1), 6, 64'h127);
    add_step(64'h1018, reg_op('h20, 0, 7, 1, 4), 7, 64'hffff_ffff_ffff_fc00);
    add_step(64'h101c, reg_op(0, 7, 8, 4, 6), 8, 64'h123);
    add_step(64'h1020, reg_op(0, 6, 9, 3, 5), 9, 64'h24);
    add_step(64'h1024, reg_op(0, 4, 10, 1, 4), 10, 64'h400);
    add_step(64'h1028, reg_op(0, 2, 11, 2, 1), 11, 64'h1);
    add_step(64'h102c, reg_op(0, 2, 12, 1, 2), 12, 64'h0);
    add_step(64'h1030, lui_op(13, 'h12345), 13, 64'h1234_5000);
    add_step(64'h1034, lui_op(14, 'h80000), 14, 64'hffff_ffff_8000_0000);
    // Write to x0, then read it back through ADD
    add_step(64'h1038, imm_op(0, 0, 1, 7), 0, 64'h0);
    add_step(64'h103c, reg_op(0, 0, 15, 0, 1), 15, 64'h123);
    // BEQ taken, BEQ not taken, BNE taken, BNE not taken
    add_step(64'h1040, branch_op(0, 1, 15, 8), 0, 64'h0);
    add_step(64'h1048, branch_op(0, 1, 2, 8), 0, 64'h0);
    add_step(64'h104c, branch_op(1, 1, 2, 8), 0, 64'h0);
    add_step(64'h1054, branch_op(1, 1, 15, 8), 0, 64'h0);
    add_step(64'h1058, jal_op(17, 16), 17, 64'h105c);
    // Backward branch into the slot the JAL skipped
    add_step(64'h1068, branch_op(1, 16, 1, -12), 0, 64'h0);
    add_step(64'h105c, imm_op(0, 16, 1, 0), 16, 64'h123);
    add_step(64'h1060, jal_op(0, 12), 0, 64'h0);
    add_step(64'h106c, imm_op(0, 19, 16, 1), 19, 64'h124);
    // Past the image
    add_step(64'h1070, NOP_WORD, 0, 64'h0);
  endtask

`endif

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_tb;

  localparam logic [`CORE_XLEN-1:0] ENTRY = 64'h1000;
  localparam int MEM_WORDS = 28;
  localparam int MAX_STEPS = 32;
  localparam logic [`CORE_ILEN-1:0] NOP_WORD = 32'h00000013;

  logic                  clk = 1'b0;
  logic                  reset;
  logic [`CORE_XLEN-1:0] entry;
  logic [`CORE_ILEN-1:0] imem_rdata;
  logic                  imem_valid;
  logic                  imem_req;
  logic [`CORE_XLEN-1:0] imem_addr;
  logic                  retire_valid;
  logic [`CORE_XLEN-1:0] retire_pc;
  logic [`CORE_RAW-1:0]  retire_rd;
  logic [`CORE_XLEN-1:0] retire_data;

  // Program image and expected retirements
  logic [`CORE_ILEN-1:0] mem [MEM_WORDS];
  logic [`CORE_XLEN-1:0] exp_pc [MAX_STEPS];
  logic [`CORE_RAW-1:0]  exp_rd [MAX_STEPS];
  logic [`CORE_XLEN-1:0] exp_data [MAX_STEPS];
  int                    n_steps;

  int                    errors;
  int                    cycle;
  int                    cycle_limit;
  int                    step;
  int                    wait_cycles;
  int                    valid_cycle;
  int                    retire_cycle;
  logic                  first_req;
  logic [31:0]           rng;
  logic [`CORE_XLEN-1:0] req_addr;

  `include "tb_program.svh"

  core_top i_dut (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .imem_rdata   (imem_rdata),
    .imem_valid   (imem_valid),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [`CORE_ILEN-1:0] read_word(input logic [`CORE_XLEN-1:0] addr);
    if (addr >= ENTRY && addr < ENTRY + 64'(4 * MEM_WORDS)) begin
      return mem[int'((addr - ENTRY) >> 2)];
    end
    return NOP_WORD;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_retire();
    check_value("retire_pc", retire_pc, exp_pc[step]);
    check_value("retire_rd", 64'(retire_rd), 64'(exp_rd[step]));
    // x0 keeps no value
    if (exp_rd[step] != '0) begin
      check_value("retire_data", retire_data, exp_data[step]);
    end
    assert (cycle == valid_cycle + 2) else begin
      errors++;
      $display("retire_valid of step %0d came %0d cycles after imem_valid instead of 2",
               step, cycle - valid_cycle);
    end
    retire_cycle = cycle;
    step++;
  endtask

  initial begin
    reset        = 1'b1;
    entry        = ENTRY;
    imem_rdata   = NOP_WORD;
    imem_valid   = 1'b0;
    errors       = 0;
    cycle        = 0;
    step         = 0;
    wait_cycles  = 0;
    valid_cycle  = -100;
    retire_cycle = -100;
    first_req    = 1'b1;
    rng          = 32'd45109;
    req_addr     = '0;
    load_program();
    cycle_limit = n_steps * 8 + 50;

    repeat (4) begin
      @(negedge clk);
      assert (!imem_req && !retire_valid) else begin
        errors++;
        $display("imem_req or retire_valid was active during reset");
      end
    end
    reset = 1'b0;

    while (step < n_steps && cycle < cycle_limit) begin
      @(negedge clk);
      cycle++;
      imem_valid = 1'b0;
      if (retire_valid) begin
        check_retire();
      end
      // Response once the drawn delay runs out
      if (wait_cycles > 0) begin
        wait_cycles--;
        if (wait_cycles == 0) begin
          check_value("imem_addr", imem_addr, req_addr);
          imem_rdata  = read_word(req_addr);
          imem_valid  = 1'b1;
          valid_cycle = cycle;
        end
      end
      if (imem_req) begin
        if (first_req) begin
          check_value("imem_addr", imem_addr, ENTRY);
          first_req = 1'b0;
        end else begin
          assert (cycle == retire_cycle + 1) else begin
            errors++;
            $display("imem_req came %0d cycles after retire_valid instead of 1",
                     cycle - retire_cycle);
          end
        end
        req_addr    = imem_addr;
        rng         = xorshift(rng);
        wait_cycles = 1 + int'(rng % 32'd4);
      end
    end

    if (step < n_steps) begin
      errors++;
      $display("Run timed out after %0d cycles with %0d of %0d retirements seen",
               cycle, step, n_steps);
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+logic
+incdir+dv
logic/core_pkg.sv
logic/issue_if.sv
logic/fetch_unit.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/core_top.sv
dv/core_tb.sv

// ==== logic/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path and address width
`define CORE_XLEN 64

// Instruction word width
`define CORE_ILEN 32

// Architectural integer registers
`define CORE_NREGS 32

// Register address width follows from the register count
`define CORE_RAW $clog2(`CORE_NREGS)

// Byte distance between sequential instructions
`define CORE_INSTR_BYTES 4

`endif

// ==== logic/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Fetch sequencing, one instruction in flight
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT,
    FETCH_BUSY
  } fetch_state_e;

  // Control word handed from decode to execute
  typedef struct packed {
    alu_op_e                alu_op;
    logic                   use_imm;
    logic [`CORE_XLEN-1:0]  imm;
    logic [`CORE_RAW-1:0]   rd;
    logic                   reg_write;
    logic                   is_branch;
    // Inverts the equality test for BNE
    logic                   branch_ne;
    logic                   is_jump;
  } decoded_t;

endpackage

// ==== logic/core_top.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`CORE_XLEN-1:0] entry,
  input  logic [`CORE_ILEN-1:0] imem_rdata,
  input  logic                  imem_valid,
  output logic                  imem_req,
  output logic [`CORE_XLEN-1:0] imem_addr,
  output logic                  retire_valid,
  output logic [`CORE_XLEN-1:0] retire_pc,
  output logic [`CORE_RAW-1:0]  retire_rd,
  output logic [`CORE_XLEN-1:0] retire_data
);

  logic                  instr_valid;
  logic [`CORE_ILEN-1:0] instr_word;
  logic [`CORE_XLEN-1:0] instr_pc;
  logic [`CORE_RAW-1:0]  rs1_addr;
  logic [`CORE_RAW-1:0]  rs2_addr;
  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;
  logic                  wr_en;
  logic [`CORE_RAW-1:0]  wr_addr;
  logic [`CORE_XLEN-1:0] wr_data;
  logic                  redirect_valid;
  logic [`CORE_XLEN-1:0] redirect_pc;

  issue_if issue_bus ();

  fetch_unit i_fetch (
    .clk            (clk),
    .reset          (reset),
    .entry          (entry),
    .imem_rdata     (imem_rdata),
    .imem_valid     (imem_valid),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .instr_valid    (instr_valid),
    .instr_word     (instr_word),
    .instr_pc       (instr_pc)
  );

  instr_decoder i_decoder (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr_word  (instr_word),
    .instr_pc    (instr_pc),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .issue       (issue_bus.decoder)
  );

  register_file i_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_unit i_execute (
    .clk            (clk),
    .reset          (reset),
    .issue          (issue_bus.execute),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data)
  );

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module execute_unit (
  input  logic                  clk,
  input  logic                  reset,
  issue_if.execute              issue,
  output logic                  wr_en,
  output logic [`CORE_RAW-1:0]  wr_addr,
  output logic [`CORE_XLEN-1:0] wr_data,
  output logic                  redirect_valid,
  output logic [`CORE_XLEN-1:0] redirect_pc,
  output logic                  retire_valid,
  output logic [`CORE_XLEN-1:0] retire_pc,
  output logic [`CORE_RAW-1:0]  retire_rd,
  output logic [`CORE_XLEN-1:0] retire_data
);

  logic [`CORE_XLEN-1:0] op_b;
  logic [`CORE_XLEN-1:0] alu_out;
  logic [`CORE_XLEN-1:0] pc_plus4;
  logic [`CORE_XLEN-1:0] result;
  logic [`CORE_XLEN-1:0] next_pc;
  logic                  taken;

  assign op_b = issue.ctrl.use_imm ? issue.ctrl.imm : issue.rs2_data;

  always_comb begin
    case (issue.ctrl.alu_op)
      core_pkg::ALU_ADD: alu_out = issue.rs1_data + op_b;
      core_pkg::ALU_SUB: alu_out = issue.rs1_data - op_b;
      core_pkg::ALU_AND: alu_out = issue.rs1_data & op_b;
      core_pkg::ALU_OR:  alu_out = issue.rs1_data | op_b;
      core_pkg::ALU_XOR: alu_out = issue.rs1_data ^ op_b;
      core_pkg::ALU_SLT: begin
        alu_out = {{(`CORE_XLEN-1){1'b0}}, $signed(issue.rs1_data) < $signed(op_b)};
      end
      core_pkg::ALU_PASS_B: alu_out = op_b;
      default:           alu_out = '0;
    endcase
  end

  assign pc_plus4 = issue.pc + `CORE_XLEN'(`CORE_INSTR_BYTES);

  // BEQ takes on equal, BNE on not equal
  assign taken = issue.ctrl.is_branch &&
                 ((issue.rs1_data == issue.rs2_data) ^ issue.ctrl.branch_ne);

  assign next_pc = (taken || issue.ctrl.is_jump) ? issue.pc + issue.ctrl.imm : pc_plus4;

  // JAL links the return address
  assign result = issue.ctrl.is_jump ? pc_plus4 : alu_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en          <= 1'b0;
      redirect_valid <= 1'b0;
      retire_valid   <= 1'b0;
    end else begin
      wr_en          <= issue.valid && issue.ctrl.reg_write;
      redirect_valid <= issue.valid;
      retire_valid   <= issue.valid;
    end
  end

  // Retirement record, rd and data read zero when nothing is written
  always_ff @(posedge clk) begin
    if (issue.valid) begin
      redirect_pc <= next_pc;
      retire_pc   <= issue.pc;
      retire_rd   <= issue.ctrl.reg_write ? issue.ctrl.rd : '0;
      retire_data <= issue.ctrl.reg_write ? result : '0;
    end
  end

  // Write-back shares the retirement payload
  assign wr_addr = retire_rd;
  assign wr_data = retire_data;

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`CORE_XLEN-1:0] entry,
  input  logic [`CORE_ILEN-1:0] imem_rdata,
  input  logic                  imem_valid,
  input  logic                  redirect_valid,
  input  logic [`CORE_XLEN-1:0] redirect_pc,
  output logic                  imem_req,
  output logic [`CORE_XLEN-1:0] imem_addr,
  output logic                  instr_valid,
  output logic [`CORE_ILEN-1:0] instr_word,
  output logic [`CORE_XLEN-1:0] instr_pc
);

  core_pkg::fetch_state_e state;
  logic [`CORE_XLEN-1:0]  pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= core_pkg::FETCH_IDLE;
      pc       <= entry;
      imem_req <= 1'b0;
    end else begin
      // Request is a single-cycle strobe
      imem_req <= 1'b0;
      case (state)
        core_pkg::FETCH_IDLE: begin
          imem_req <= 1'b1;
          state    <= core_pkg::FETCH_WAIT;
        end
        core_pkg::FETCH_WAIT: begin
          if (imem_valid) begin
            state <= core_pkg::FETCH_BUSY;
          end
        end
        core_pkg::FETCH_BUSY: begin
          // Redirect starts the next request right away
          if (redirect_valid) begin
            pc       <= redirect_pc;
            imem_req <= 1'b1;
            state    <= core_pkg::FETCH_WAIT;
          end
        end
        default: begin
          state <= core_pkg::FETCH_IDLE;
        end
      endcase
    end
  end

  // Address stays on pc until the response returns
  assign imem_addr = pc;

  // Responses outside WAIT are dropped
  assign instr_valid = (state == core_pkg::FETCH_WAIT) && imem_valid;
  assign instr_word  = imem_rdata;
  assign instr_pc    = pc;

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module instr_decoder (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  instr_valid,
  input  logic [`CORE_ILEN-1:0] instr_word,
  input  logic [`CORE_XLEN-1:0] instr_pc,
  output logic [`CORE_RAW-1:0]  rs1_addr,
  output logic [`CORE_RAW-1:0]  rs2_addr,
  input  logic [`CORE_XLEN-1:0] rs1_data,
  input  logic [`CORE_XLEN-1:0] rs2_data,
  issue_if.decoder              issue
);

  core_pkg::opcode_e     opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`CORE_RAW-1:0]  rd_field;
  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_u;
  logic [`CORE_XLEN-1:0] imm_j;
  logic [`CORE_XLEN-1:0] imm_b;
  core_pkg::decoded_t    dec;

  assign opcode   = core_pkg::opcode_e'(instr_word[6:0]);
  assign funct3   = instr_word[14:12];
  assign funct7   = instr_word[31:25];
  assign rd_field = instr_word[11:7];
  assign rs1_addr = instr_word[19:15];
  assign rs2_addr = instr_word[24:20];

  // Sign-extended immediates
  assign imm_i = {{(`CORE_XLEN-12){instr_word[31]}}, instr_word[31:20]};
  assign imm_u = {{(`CORE_XLEN-32){instr_word[31]}}, instr_word[31:12], 12'b0};
  assign imm_j = {{(`CORE_XLEN-21){instr_word[31]}}, instr_word[31], instr_word[19:12],
                  instr_word[20], instr_word[30:21], 1'b0};
  assign imm_b = {{(`CORE_XLEN-13){instr_word[31]}}, instr_word[31], instr_word[7],
                  instr_word[30:25], instr_word[11:8], 1'b0};

  always_comb begin
    // Anything not matched below retires as a no-op
    dec    = '0;
    dec.rd = rd_field;
    case (opcode)
      core_pkg::OP_IMM: begin
        dec.use_imm   = 1'b1;
        dec.imm       = imm_i;
        dec.reg_write = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = core_pkg::ALU_ADD;
          3'b111:  dec.alu_op = core_pkg::ALU_AND;
          3'b110:  dec.alu_op = core_pkg::ALU_OR;
          3'b100:  dec.alu_op = core_pkg::ALU_XOR;
          default: dec.reg_write = 1'b0;
        endcase
      end
      core_pkg::OP: begin
        dec.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec.alu_op = core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: dec.alu_op = core_pkg::ALU_SUB;
          {7'b0000000, 3'b111}: dec.alu_op = core_pkg::ALU_AND;
          {7'b0000000, 3'b110}: dec.alu_op = core_pkg::ALU_OR;
          {7'b0000000, 3'b100}: dec.alu_op = core_pkg::ALU_XOR;
          {7'b0000000, 3'b010}: dec.alu_op = core_pkg::ALU_SLT;
          default:              dec.reg_write = 1'b0;
        endcase
      end
      core_pkg::LUI: begin
        dec.alu_op    = core_pkg::ALU_PASS_B;
        dec.use_imm   = 1'b1;
        dec.imm       = imm_u;
        dec.reg_write = 1'b1;
      end
      core_pkg::JAL: begin
        dec.imm       = imm_j;
        dec.is_jump   = 1'b1;
        dec.reg_write = 1'b1;
      end
      core_pkg::BRANCH: begin
        dec.imm = imm_b;
        // Only BEQ and BNE
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          dec.is_branch = 1'b1;
          dec.branch_ne = funct3[0];
        end
      end
      default: begin
        dec.reg_write = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= instr_valid;
    end
  end

  // Operands sampled in the same cycle as the fetch response
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      issue.pc       <= instr_pc;
      issue.ctrl     <= dec;
      issue.rs1_data <= rs1_data;
      issue.rs2_data <= rs2_data;
    end
  end

endmodule

// ==== logic/issue_if.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

interface issue_if;

  // One-cycle strobe, payload holds until the next strobe
  logic                  valid;
  logic [`CORE_XLEN-1:0] pc;
  core_pkg::decoded_t    ctrl;
  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;

  modport decoder (
    output valid,
    output pc,
    output ctrl,
    output rs1_data,
    output rs2_data
  );

  modport execute (
    input valid,
    input pc,
    input ctrl,
    input rs1_data,
    input rs2_data
  );

endinterface

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module register_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`CORE_RAW-1:0]  rs1_addr,
  input  logic [`CORE_RAW-1:0]  rs2_addr,
  input  logic                  wr_en,
  input  logic [`CORE_RAW-1:0]  wr_addr,
  input  logic [`CORE_XLEN-1:0] wr_data,
  output logic [`CORE_XLEN-1:0] rs1_data,
  output logic [`CORE_XLEN-1:0] rs2_data
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      // x0 never takes a write, so it stays zero from reset
      regs[wr_addr] <= wr_data;
    end
  end

  // Asynchronous read ports
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module core_tb -f files.f -o core_sim
./obj_dir/core_sim > sim.log
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation passed"
